// ==== hdl/wb_bridge_macros.svh ====
`ifndef WB_BRIDGE_MACROS_SVH
`define WB_BRIDGE_MACROS_SVH

// wishbone bus widths
`define WB_ADDR_W 32
`define WB_DATA_W 32

// register RAM depth in 32-bit words, 64 words cover byte addresses 0..255
`define RAM_WORDS 64

// answer for reads that fall outside the RAM
`define RAM_MISS_DATA 32'hDEAD_BEEF

`endif

// ==== hdl/wb_bridge_pkg.sv ====
`default_nettype none

`include "wb_bridge_macros.svh"

package wb_bridge_pkg;

    // host command opcodes, same encoding as the host link
    typedef enum logic [1:0] {
        READ    = 2'd0,
        WRITE   = 2'd1,
        ADDR    = 2'd2,
        SPECIAL = 2'd3
    } cmd_op_e;

    typedef enum logic [1:0] {
        IDLE,  // waiting for a command word
        BUS,   // wishbone cycle open
        RESP   // response word on the link
    } master_state_e;

    // 34-bit command word from the host
    typedef struct packed {
        cmd_op_e               op;
        logic [`WB_DATA_W-1:0] payload;
    } cmd_word_t;

    // 34-bit response word back to the host
    typedef struct packed {
        cmd_op_e               op;
        logic [`WB_DATA_W-1:0] data;
    } rsp_word_t;

    // master to slave
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`WB_ADDR_W-1:0] adr;
        logic [`WB_DATA_W-1:0] dat_w;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic                  ack;
        logic [`WB_DATA_W-1:0] dat_r;
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/wb_cmd_master.sv ====
`default_nettype none

`include "wb_bridge_macros.svh"

module wb_cmd_master (
    input  wire logic                     clk,
    input  wire logic                     rst,

    // host command link
    input  wire logic                     i_cmd_valid,
    input  wire wb_bridge_pkg::cmd_word_t i_cmd,
    output logic                          o_cmd_ready,

    // host response link, no back-pressure
    output logic                          o_rsp_valid,
    output wb_bridge_pkg::rsp_word_t      o_rsp,

    // wishbone side, through the arbiter
    output wb_bridge_pkg::wb_req_t        o_wb,
    input  wire wb_bridge_pkg::wb_rsp_t   i_wb,
    input  wire logic                     i_gnt
);

    wb_bridge_pkg::master_state_e state_q;
    wb_bridge_pkg::cmd_op_e       op_q;        // opcode echoed in the response

    logic [`WB_ADDR_W-1:0] addr_q;             // latched by ADDR
    logic [`WB_DATA_W-1:0] wdat_q;
    logic [`WB_DATA_W-1:0] rsp_data_q;
    logic                  we_q;
    logic                  strobed_q;          // stb already issued in this cycle
    logic                  accept;
    logic                  cyc;
    logic                  stb;

    assign o_cmd_ready = (state_q == wb_bridge_pkg::IDLE);
    assign accept      = i_cmd_valid && o_cmd_ready;

    assign cyc = (state_q == wb_bridge_pkg::BUS);
    // single strobe in the first granted cycle, cyc alone while waiting
    assign stb = cyc && i_gnt && !strobed_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= wb_bridge_pkg::IDLE;
            addr_q    <= '0;
            strobed_q <= 1'b0;
        end else begin
            if (stb)
                strobed_q <= 1'b1;

            case (state_q)
                wb_bridge_pkg::IDLE: begin
                    if (accept) begin
                        case (i_cmd.op)
                            wb_bridge_pkg::READ,
                            wb_bridge_pkg::WRITE: begin
                                state_q <= wb_bridge_pkg::BUS;
                            end
                            wb_bridge_pkg::ADDR: begin
                                addr_q  <= i_cmd.payload;
                                state_q <= wb_bridge_pkg::RESP;
                            end
                            default: begin
                                state_q <= wb_bridge_pkg::RESP;  // SPECIAL
                            end
                        endcase
                    end
                end
                wb_bridge_pkg::BUS: begin
                    if (i_wb.ack) begin
                        state_q   <= wb_bridge_pkg::RESP;
                        strobed_q <= 1'b0;
                    end
                end
                wb_bridge_pkg::RESP: begin
                    state_q <= wb_bridge_pkg::IDLE;  // response lasts one cycle
                end
                default: begin
                    state_q <= wb_bridge_pkg::IDLE;
                end
            endcase
        end
    end

    // command payload and response data
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q   <= i_cmd.op;
            we_q   <= (i_cmd.op == wb_bridge_pkg::WRITE);
            wdat_q <= i_cmd.payload;
            // SPECIAL reports the address in force, everything else starts at 0
            if (i_cmd.op == wb_bridge_pkg::SPECIAL)
                rsp_data_q <= addr_q;
            else
                rsp_data_q <= '0;
        end else if (cyc && i_wb.ack && !we_q) begin
            rsp_data_q <= i_wb.dat_r;
        end
    end

    assign o_wb = '{
        cyc:   cyc,
        stb:   stb,
        we:    we_q,
        adr:   addr_q,
        dat_w: wdat_q
    };

    assign o_rsp_valid = (state_q == wb_bridge_pkg::RESP);
    assign o_rsp       = '{op: op_q, data: rsp_data_q};

    // one strobe per cycle, the next only after the slave has answered
    a_no_stb_before_ack: assert property (
        @(posedge clk) disable iff (rst)
        o_wb.stb |=> (!o_wb.stb until_with i_wb.ack)
    );

    a_rsp_single: assert property (
        @(posedge clk) disable iff (rst)
        o_rsp_valid |=> !o_rsp_valid
    );

endmodule

`default_nettype wire

// ==== hdl/wb_arbiter.sv ====
`default_nettype none

module wb_arbiter (
    input  wire logic                   clk,
    input  wire logic                   rst,

    input  wire wb_bridge_pkg::wb_req_t i_req_a,
    input  wire wb_bridge_pkg::wb_req_t i_req_b,
    output logic                        o_gnt_a,
    output logic                        o_gnt_b,
    output wb_bridge_pkg::wb_rsp_t      o_rsp_a,
    output wb_bridge_pkg::wb_rsp_t      o_rsp_b,

    // shared bus to the slave
    output wb_bridge_pkg::wb_req_t      o_bus,
    input  wire wb_bridge_pkg::wb_rsp_t i_bus
);

    logic [1:0] owner_q;   // {b, a}, who held the bus last cycle
    logic       last_b_q;  // b got the most recent grant
    logic       hold_a;
    logic       hold_b;

    // an owner keeps the bus until its cyc falls
    assign hold_a = owner_q[0] && i_req_a.cyc;
    assign hold_b = owner_q[1] && i_req_b.cyc;

    always_comb begin
        if (hold_a || hold_b) begin
            o_gnt_a = hold_a;
            o_gnt_b = hold_b;
        end else begin
            // bus free, a tie goes to the one not served last
            o_gnt_a = i_req_a.cyc && (!i_req_b.cyc || last_b_q);
            o_gnt_b = i_req_b.cyc && (!i_req_a.cyc || !last_b_q);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            owner_q  <= 2'b00;
            last_b_q <= 1'b0;
        end else begin
            owner_q <= {o_gnt_b, o_gnt_a};
            if (o_gnt_a || o_gnt_b)
                last_b_q <= o_gnt_b;
        end
    end

    always_comb begin
        if (o_gnt_a)
            o_bus = i_req_a;
        else if (o_gnt_b)
            o_bus = i_req_b;
        else
            o_bus = '0;  // idle bus
    end

    // read data goes to both, ack only to the owner
    assign o_rsp_a = '{ack: i_bus.ack && o_gnt_a, dat_r: i_bus.dat_r};
    assign o_rsp_b = '{ack: i_bus.ack && o_gnt_b, dat_r: i_bus.dat_r};

    a_gnt_onehot: assert property (
        @(posedge clk) disable iff (rst)
        !(o_gnt_a && o_gnt_b)
    );

endmodule

`default_nettype wire

// ==== hdl/wb_reg_ram.sv ====
`default_nettype none

`include "wb_bridge_macros.svh"

module wb_reg_ram (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire wb_bridge_pkg::wb_req_t i_wb,
    output wb_bridge_pkg::wb_rsp_t      o_wb
);

    localparam int IDX_W = $clog2(`RAM_WORDS);

    logic [`WB_DATA_W-1:0] mem [`RAM_WORDS];
    logic [IDX_W-1:0]      idx;
    logic                  in_range;
    logic                  ack_q;
    logic [`WB_DATA_W-1:0] rdat_q;

    // word addressed, byte offset bits ignored
    assign idx      = i_wb.adr[IDX_W+1:2];
    assign in_range = (i_wb.adr[`WB_ADDR_W-1:IDX_W+2] == '0);

    always_ff @(posedge clk) begin
        if (rst)
            ack_q <= 1'b0;
        else
            ack_q <= i_wb.stb;  // one ack per strobe, next cycle
    end

    always_ff @(posedge clk) begin
        if (i_wb.stb) begin
            if (i_wb.we && in_range)
                mem[idx] <= i_wb.dat_w;  // out of range writes are dropped

            if (in_range)
                rdat_q <= mem[idx];
            else
                rdat_q <= `RAM_MISS_DATA;
        end
    end

    assign o_wb = '{ack: ack_q, dat_r: rdat_q};

    // strobe only inside an open cycle
    a_stb_in_cyc: assert property (
        @(posedge clk) disable iff (rst)
        i_wb.stb |-> i_wb.cyc
    );

    a_ack_after_stb: assert property (
        @(posedge clk) disable iff (rst)
        o_wb.ack |-> $past(i_wb.stb && i_wb.cyc)
    );

endmodule

`default_nettype wire

// ==== hdl/wb_bridge_top.sv ====
`default_nettype none

module wb_bridge_top (
    input  wire logic                     clk,
    input  wire logic                     rst,

    // host link A
    input  wire logic                     i_a_cmd_valid,
    input  wire wb_bridge_pkg::cmd_word_t i_a_cmd,
    output logic                          o_a_cmd_ready,
    output logic                          o_a_rsp_valid,
    output wb_bridge_pkg::rsp_word_t      o_a_rsp,

    // host link B
    input  wire logic                     i_b_cmd_valid,
    input  wire wb_bridge_pkg::cmd_word_t i_b_cmd,
    output logic                          o_b_cmd_ready,
    output logic                          o_b_rsp_valid,
    output wb_bridge_pkg::rsp_word_t      o_b_rsp
);

    wb_bridge_pkg::wb_req_t req_a;
    wb_bridge_pkg::wb_req_t req_b;
    wb_bridge_pkg::wb_req_t bus_req;   // granted request toward the RAM
    wb_bridge_pkg::wb_rsp_t rsp_a;
    wb_bridge_pkg::wb_rsp_t rsp_b;
    wb_bridge_pkg::wb_rsp_t bus_rsp;
    logic                   gnt_a;
    logic                   gnt_b;

    wb_cmd_master u_master_a (
        .clk         (clk),
        .rst         (rst),
        .i_cmd_valid (i_a_cmd_valid),
        .i_cmd       (i_a_cmd),
        .o_cmd_ready (o_a_cmd_ready),
        .o_rsp_valid (o_a_rsp_valid),
        .o_rsp       (o_a_rsp),
        .o_wb        (req_a),
        .i_wb        (rsp_a),
        .i_gnt       (gnt_a)
    );

    wb_cmd_master u_master_b (
        .clk         (clk),
        .rst         (rst),
        .i_cmd_valid (i_b_cmd_valid),
        .i_cmd       (i_b_cmd),
        .o_cmd_ready (o_b_cmd_ready),
        .o_rsp_valid (o_b_rsp_valid),
        .o_rsp       (o_b_rsp),
        .o_wb        (req_b),
        .i_wb        (rsp_b),
        .i_gnt       (gnt_b)
    );

    wb_arbiter u_arbiter (
        .clk     (clk),
        .rst     (rst),
        .i_req_a (req_a),
        .i_req_b (req_b),
        .o_gnt_a (gnt_a),
        .o_gnt_b (gnt_b),
        .o_rsp_a (rsp_a),
        .o_rsp_b (rsp_b),
        .o_bus   (bus_req),
        .i_bus   (bus_rsp)
    );

    wb_reg_ram u_ram (
        .clk  (clk),
        .rst  (rst),
        .i_wb (bus_req),
        .o_wb (bus_rsp)
    );

endmodule

`default_nettype wire

// ==== bench/wb_bridge_tb.sv ====
`default_nettype none

module wb_bridge_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 50;  // cycles allowed per wait

    logic                            clk;
    logic                            rst;
    logic [1:0]                      cmd_valid;
    wb_bridge_pkg::cmd_word_t [1:0]  cmd;
    wire  [1:0]                      cmd_ready;
    wire  [1:0]                      rsp_valid;
    wire  wb_bridge_pkg::rsp_word_t  rsp_a;
    wire  wb_bridge_pkg::rsp_word_t  rsp_b;

    wb_bridge_pkg::rsp_word_t [1:0]  exp_rsp;    // expected word per link
    logic [1:0]                      chk_rsp;
    logic                            solo_chk;   // link B idle, exact bus latency
    logic [1:0][31:0]                link_addr;  // address each master holds
    logic [31:0]                     model [64]; // reference copy of the RAM
    logic [63:0]                     written;
    string                           test_name;
    integer                          seed = 32'h7d165268;
    logic [31:0]                     addr_a;
    logic [31:0]                     addr_b;
    logic [31:0]                     dat_a;
    logic [31:0]                     dat_b;

    wb_bridge_top wb_bridge_top_i (
        .clk           (clk),
        .rst           (rst),
        .i_a_cmd_valid (cmd_valid[0]),
        .i_a_cmd       (cmd[0]),
        .o_a_cmd_ready (cmd_ready[0]),
        .o_a_rsp_valid (rsp_valid[0]),
        .o_a_rsp       (rsp_a),
        .i_b_cmd_valid (cmd_valid[1]),
        .i_b_cmd       (cmd[1]),
        .o_b_cmd_ready (cmd_ready[1]),
        .o_b_rsp_valid (rsp_valid[1]),
        .o_b_rsp       (rsp_b)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    // one command on one link, expected response worked out from the RAM model
    task automatic send_cmd(input int link, input wb_bridge_pkg::cmd_op_e op,
                            input logic [31:0] payload);
        wb_bridge_pkg::rsp_word_t exp;
        logic [31:0]              adr;
        int                       waited;
        adr           = link_addr[link];
        exp           = '{op: op, data: 32'h0};
        chk_rsp[link] = 1'b1;
        case (op)
            wb_bridge_pkg::ADDR:    link_addr[link] = payload;
            wb_bridge_pkg::SPECIAL: exp.data = adr;
            wb_bridge_pkg::WRITE: begin
                if (adr < 256) begin
                    model[adr[7:2]]   = payload;
                    written[adr[7:2]] = 1'b1;
                end
            end
            default: begin  // READ
                if (adr >= 256)
                    exp.data = 32'hDEAD_BEEF;
                else begin
                    exp.data      = model[adr[7:2]];
                    chk_rsp[link] = written[adr[7:2]];
                end
            end
        endcase
        exp_rsp[link] = exp;
        @(negedge clk);
        cmd_valid[link] = 1'b1;
        cmd[link]       = '{op: op, payload: payload};
        waited = 0;
        while (!cmd_ready[link]) begin
            if (waited == TIMEOUT)
                fail_stop($sformatf("%s: link %0d never became ready", test_name, link));
            @(negedge clk);
            waited++;
        end
        @(negedge clk);  // accepted on the rising edge just passed
        cmd_valid[link] = 1'b0;
        waited = 0;
        while (!rsp_valid[link]) begin
            if (waited == TIMEOUT)
                fail_stop($sformatf("%s: no response on link %0d", test_name, link));
            @(negedge clk);
            waited++;
        end
        @(negedge clk);  // hold exp_rsp until the pulse has been sampled
    endtask

    a_rsp_a: assert property (@(posedge clk) disable iff (rst)
        (rsp_valid[0] && chk_rsp[0]) |-> (rsp_a == exp_rsp[0]))
        else fail_stop($sformatf("[ERROR] %s link A: expected %h, actual %h",
                                 test_name, $sampled(exp_rsp[0]), $sampled(rsp_a)));

    a_rsp_b: assert property (@(posedge clk) disable iff (rst)
        (rsp_valid[1] && chk_rsp[1]) |-> (rsp_b == exp_rsp[1]))
        else fail_stop($sformatf("[ERROR] %s link B: expected %h, actual %h",
                                 test_name, $sampled(exp_rsp[1]), $sampled(rsp_b)));

    // a master is busy from acceptance until its response pulse
    a_busy_a: assert property (@(posedge clk) disable iff (rst)
        (cmd_valid[0] && cmd_ready[0]) |=> (!cmd_ready[0] until_with rsp_valid[0]))
        else fail_stop($sformatf("%s: link A was ready again before its response",
                                 test_name));

    a_busy_b: assert property (@(posedge clk) disable iff (rst)
        (cmd_valid[1] && cmd_ready[1]) |=> (!cmd_ready[1] until_with rsp_valid[1]))
        else fail_stop($sformatf("%s: link B was ready again before its response",
                                 test_name));

    // ADDR and SPECIAL answer in the next cycle
    a_lat_local: assert property (@(posedge clk) disable iff (rst)
        (cmd_valid[0] && cmd_ready[0] && (cmd[0].op == wb_bridge_pkg::ADDR ||
         cmd[0].op == wb_bridge_pkg::SPECIAL)) |=> rsp_valid[0])
        else fail_stop($sformatf("%s: link A local command did not answer in one cycle",
                                 test_name));

    // strobe cycle, ack cycle, then the response
    a_lat_bus: assert property (@(posedge clk) disable iff (rst)
        (cmd_valid[0] && cmd_ready[0] && solo_chk && (cmd[0].op == wb_bridge_pkg::READ ||
         cmd[0].op == wb_bridge_pkg::WRITE))
        |=> !rsp_valid[0] ##1 !rsp_valid[0] ##1 rsp_valid[0])
        else fail_stop($sformatf("%s: link A bus command did not answer in three cycles",
                                 test_name));

    initial begin
        rst       = 1'b1;
        cmd_valid = '0;
        cmd       = '0;
        exp_rsp   = '0;
        chk_rsp   = '0;
        solo_chk  = 1'b0;
        link_addr = '0;
        written   = '0;
        test_name = "reset";
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_name = "addr_special";
        addr_a = $random(seed) & 32'hFC;  // word aligned, inside the RAM
        send_cmd(0, wb_bridge_pkg::ADDR, addr_a);
        send_cmd(0, wb_bridge_pkg::SPECIAL, 32'h0);

        test_name = "write_read";
        solo_chk  = 1'b1;
        send_cmd(0, wb_bridge_pkg::WRITE, $random(seed));
        send_cmd(0, wb_bridge_pkg::READ, 32'h0);

        test_name = "latency";
        send_cmd(0, wb_bridge_pkg::READ, 32'h0);
        solo_chk = 1'b0;

        test_name = "contention";
        addr_b = addr_a ^ 32'h4;
        dat_a  = $random(seed);
        dat_b  = $random(seed);
        fork
            send_cmd(0, wb_bridge_pkg::ADDR, addr_a);
            send_cmd(1, wb_bridge_pkg::ADDR, addr_b);
        join
        fork
            send_cmd(0, wb_bridge_pkg::WRITE, dat_a);
            send_cmd(1, wb_bridge_pkg::WRITE, dat_b);
        join
        fork
            send_cmd(0, wb_bridge_pkg::READ, 32'h0);
            send_cmd(1, wb_bridge_pkg::READ, 32'h0);
        join

        test_name = "shared";
        send_cmd(1, wb_bridge_pkg::ADDR, addr_a);
        send_cmd(1, wb_bridge_pkg::READ, 32'h0);

        // aliases addr_a in the low bits, so a leaked write would show up there
        test_name = "out_of_range";
        send_cmd(0, wb_bridge_pkg::ADDR, addr_a | 32'h100);
        send_cmd(0, wb_bridge_pkg::WRITE, ~dat_a);
        send_cmd(0, wb_bridge_pkg::READ, 32'h0);
        send_cmd(0, wb_bridge_pkg::ADDR, addr_a);
        send_cmd(0, wb_bridge_pkg::READ, 32'h0);

        repeat (4) @(negedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+hdl
hdl/wb_bridge_pkg.sv
hdl/wb_cmd_master.sv
hdl/wb_arbiter.sv
hdl/wb_reg_ram.sv
hdl/wb_bridge_top.sv
bench/wb_bridge_tb.sv
